/* dv/udp10g_tx_asserts.sv */
`timescale 1ns/1ps

module udp10g_tx_asserts (
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_tx_tready,
    input logic [63:0] o_tx_tdata,
    input logic [7:0]  o_tx_tkeep,
    input logic        o_tx_tvalid,
    input logic        o_tx_tlast
);

    // Stalled beat holds until taken
    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_tx_tvalid && !i_tx_tready) |=> (o_tx_tvalid && $stable(o_tx_tdata)
            && $stable(o_tx_tkeep) && $stable(o_tx_tlast)))
        else $error("output changed while stalled");

    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_tx_tvalid && !o_tx_tlast) |-> (o_tx_tkeep == 8'hff))
        else $error("partial tkeep on a middle beat");

    assert property (@(posedge i_clk) i_rst |=> !o_tx_tvalid)
        else $error("tvalid high during reset");

endmodule

bind udp_frame_tx udp10g_tx_asserts u_asserts (
    .i_clk       ( i_clk       ),
    .i_rst       ( i_rst       ),
    .i_tx_tready ( i_tx_tready ),
    .o_tx_tdata  ( o_tx_tdata  ),
    .o_tx_tkeep  ( o_tx_tkeep  ),
    .o_tx_tvalid ( o_tx_tvalid ),
    .o_tx_tlast  ( o_tx_tlast  )
);

/* dv/udp10g_tx_tb.sv */
`timescale 1ns/1ps

module udp10g_tx_tb;

    localparam int NUM_FRAMES = 11;
    localparam longint TIMEOUT_NS = (NUM_FRAMES * 22 * 4 + 3000) * 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        csr_wr_en;
    logic [3:0]  csr_addr;
    logic [31:0] csr_wr_data;
    logic [63:0] pay_tdata;
    logic        pay_tvalid;
    logic        pay_tlast;
    logic        tx_tready;
    logic [31:0] csr_rd_data;
    logic        pay_tready;
    logic [63:0] tx_tdata;
    logic [7:0]  tx_tkeep;
    logic        tx_tvalid;
    logic        tx_tlast;

    logic [31:0] lfsr_state = 32'h3e24;

    // Current frame fields as the model sees them
    logic [47:0] f_dmac;
    logic [47:0] f_smac;
    logic [31:0] f_sip;
    logic [31:0] f_dip;
    logic [15:0] f_sport;
    logic [15:0] f_dport;
    logic [7:0]  f_ttl;
    logic [63:0] model_words[$];

    logic [63:0] pay_words[$];
    logic        pay_lasts[$];
    logic [7:0]  exp_bytes[$];
    int          exp_n[$];
    logic [7:0]  got_bytes[$];

    int got_beats = 0;
    int frames_done = 0;
    int frames_sent = 0;
    int exp_beat_sum = 0;
    int errors = 0;
    bit stall_mode = 1'b0;
    bit ramp_mode = 1'b0;
    bit pay_acc_seen = 1'b0;

    udp10g_tx DUT (
        .i_clk         ( clk         ),
        .i_rst         ( rst         ),
        .i_csr_wr_en   ( csr_wr_en   ),
        .i_csr_addr    ( csr_addr    ),
        .i_csr_wr_data ( csr_wr_data ),
        .i_pay_tdata   ( pay_tdata   ),
        .i_pay_tvalid  ( pay_tvalid  ),
        .i_pay_tlast   ( pay_tlast   ),
        .i_tx_tready   ( tx_tready   ),
        .o_csr_rd_data ( csr_rd_data ),
        .o_pay_tready  ( pay_tready  ),
        .o_tx_tdata    ( tx_tdata    ),
        .o_tx_tkeep    ( tx_tkeep    ),
        .o_tx_tvalid   ( tx_tvalid   ),
        .o_tx_tlast    ( tx_tlast    )
    );

    always #50 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // Expected frame built byte by byte from the protocol rules
    task automatic push_frame_model(input int n);
        logic [7:0]  h[42];
        logic [15:0] ulen;
        logic [15:0] tot;
        logic [31:0] sum;
        ulen = 16'(8 + 8 * n);
        tot  = 16'(20) + ulen;
        for (int i = 0; i < 6; i++) begin
            h[i]     = f_dmac[47 - 8*i -: 8];
            h[6 + i] = f_smac[47 - 8*i -: 8];
        end
        h[12] = 8'h08;
        h[13] = 8'h00;
        h[14] = 8'h45;
        h[15] = 8'h00;
        h[16] = tot[15:8];
        h[17] = tot[7:0];
        for (int i = 18; i < 22; i++) h[i] = 8'h00;
        h[22] = f_ttl;
        h[23] = 8'd17;
        h[24] = 8'h00;
        h[25] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            h[26 + i] = f_sip[31 - 8*i -: 8];
            h[30 + i] = f_dip[31 - 8*i -: 8];
        end
        h[34] = f_sport[15:8];
        h[35] = f_sport[7:0];
        h[36] = f_dport[15:8];
        h[37] = f_dport[7:0];
        h[38] = ulen[15:8];
        h[39] = ulen[7:0];
        h[40] = 8'h00;
        h[41] = 8'h00;
        sum = 0;
        for (int i = 14; i < 34; i += 2) sum += {16'h0, h[i], h[i + 1]};
        while (sum[31:16] != 0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        h[24] = ~sum[15:8];
        h[25] = ~sum[7:0];
        foreach (h[i]) exp_bytes.push_back(h[i]);
        foreach (model_words[w]) begin
            for (int b = 0; b < 8; b++) exp_bytes.push_back(model_words[w][8*b +: 8]);
        end
        exp_n.push_back(n);
        exp_beat_sum += n + 6;
        frames_sent++;
    endtask

    task automatic check_frame();
        int n;
        logic [7:0] e;
        if (exp_n.size() == 0) begin
            report_error("a frame came out that was never requested");
        end
        n = exp_n.pop_front();
        assert (got_beats == n + 6)
            else report_error($sformatf("frame has %0d beats, expected %0d", got_beats, n + 6));
        assert (got_bytes.size() == 42 + 8 * n)
            else report_error($sformatf("frame has %0d bytes", got_bytes.size()));
        foreach (got_bytes[i]) begin
            e = exp_bytes.pop_front();
            assert (got_bytes[i] == e)
                else report_error($sformatf("frame %0d byte %0d is %h, expected %h",
                                            frames_done, i, got_bytes[i], e));
        end
        got_bytes.delete();
        got_beats = 0;
        frames_done++;
    endtask

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clk) begin
        if (!rst && tx_tvalid && tx_tready) begin
            got_beats++;
            if (tx_tlast) begin
                assert (tx_tkeep == 8'h03)
                    else report_error($sformatf("last tkeep %h", tx_tkeep));
            end else begin
                assert (tx_tkeep == 8'hff)
                    else report_error($sformatf("tkeep %h on a middle beat", tx_tkeep));
            end
            for (int b = 0; b < 8; b++) begin
                if (tx_tkeep[b]) got_bytes.push_back(tx_tdata[8*b +: 8]);
            end
            if (tx_tlast) check_frame();
        end
        if (!rst && ramp_mode) begin
            assert (pay_tready == 1'b0)
                else report_error("o_pay_tready high while ramp is enabled");
        end
        pay_acc_seen = pay_tvalid && pay_tready;
    end

    // External payload source holding valid until accepted
    always @(posedge clk) begin
        if (rst) begin
            pay_tvalid <= 1'b0;
            pay_tdata  <= '0;
            pay_tlast  <= 1'b0;
        end else begin
            if (pay_acc_seen) begin
                void'(pay_words.pop_front());
                void'(pay_lasts.pop_front());
            end
            if (!pay_tvalid || pay_acc_seen) begin
                if (pay_words.size() > 0 && rnd(2) != 0) begin
                    pay_tvalid <= 1'b1;
                    pay_tdata  <= pay_words[0];
                    pay_tlast  <= pay_lasts[0];
                end else begin
                    pay_tvalid <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            tx_tready <= 1'b0;
        end else begin
            tx_tready <= stall_mode ? (rnd(2) != 0) : 1'b1;
        end
    end

    task automatic csr_write(input logic [3:0] a, input logic [31:0] d);
        @(posedge clk);
        csr_wr_en   <= 1'b1;
        csr_addr    <= a;
        csr_wr_data <= d;
        @(posedge clk);
        csr_wr_en   <= 1'b0;
    endtask

    task automatic csr_read_check(input logic [3:0] a, input logic [31:0] exp);
        @(posedge clk);
        csr_addr <= a;
        @(negedge clk);
        assert (csr_rd_data == exp)
            else report_error($sformatf("reg %0d reads %h, expected %h", a, csr_rd_data, exp));
    endtask

    function automatic logic [31:0] reg_mask(input int a);
        case (a)
            0:             return 32'h1;
            3, 5:          return 32'hffff;
            9:             return 32'hff_ffff;
            2, 4, 6, 7, 8: return 32'hffff_ffff;
            default:       return 32'h0;
        endcase
    endfunction

    task automatic readback_test();
        logic [31:0] d;
        for (int a = 0; a < 16; a++) begin
            d = rnd(32);
            if (a == 1) d[0] = 1'b0;
            csr_write(4'(a), d);
            csr_read_check(4'(a), d & reg_mask(a));
        end
    endtask

    // Mode 0 is plain, 1 rewrites fields mid frame and 2 queues a second send
    task automatic send_frame(input bit ext, input bit stall, input int mode);
        int n;
        int lat;
        logic [63:0] w;
        ramp_mode  = !ext;
        stall_mode = stall;
        f_dmac  = {16'(rnd(16)), rnd(32)};
        f_smac  = {16'(rnd(16)), rnd(32)};
        f_sip   = rnd(32);
        f_dip   = rnd(32);
        f_sport = 16'(rnd(16));
        f_dport = 16'(rnd(16));
        f_ttl   = 8'(rnd(8));
        n = 1 + rnd(4);
        csr_write(udp_tx_pkg::ADDR_SRC_MAC_LO, f_smac[31:0]);
        csr_write(udp_tx_pkg::ADDR_SRC_MAC_HI, {16'h0, f_smac[47:32]});
        csr_write(udp_tx_pkg::ADDR_DST_MAC_LO, f_dmac[31:0]);
        csr_write(udp_tx_pkg::ADDR_DST_MAC_HI, {16'h0, f_dmac[47:32]});
        csr_write(udp_tx_pkg::ADDR_SRC_IP, f_sip);
        csr_write(udp_tx_pkg::ADDR_DST_IP, f_dip);
        csr_write(udp_tx_pkg::ADDR_PORTS, {f_sport, f_dport});
        csr_write(udp_tx_pkg::ADDR_LEN_TTL, {8'h0, f_ttl, 16'(n)});
        csr_write(udp_tx_pkg::ADDR_CTRL, {31'h0, !ext});
        model_words.delete();
        for (int k = 0; k < n; k++) begin
            w = ext ? {rnd(32), rnd(32)} : 64'(k);
            model_words.push_back(w);
            if (ext) begin
                pay_words.push_back(w);
                pay_lasts.push_back(k == n - 1);
            end
        end
        push_frame_model(n);
        csr_write(udp_tx_pkg::ADDR_SEND, 32'h1);
        lat = 0;
        while (!tx_tvalid) begin
            @(negedge clk);
            lat++;
        end
        assert (lat == 3)
            else report_error($sformatf("tvalid rose %0d cycles after the send write", lat));
        if (mode == 1) begin
            csr_write(udp_tx_pkg::ADDR_SRC_MAC_LO, rnd(32));
            csr_write(udp_tx_pkg::ADDR_DST_MAC_HI, rnd(32));
            csr_write(udp_tx_pkg::ADDR_SRC_IP, rnd(32));
            csr_write(udp_tx_pkg::ADDR_DST_IP, rnd(32));
            csr_write(udp_tx_pkg::ADDR_PORTS, rnd(32));
            csr_write(udp_tx_pkg::ADDR_LEN_TTL, {8'h0, 8'(rnd(8)), 16'(n)});
        end
        if (mode == 2) begin
            // Second write while pending must be absorbed
            csr_write(udp_tx_pkg::ADDR_SEND, 32'h1);
            csr_write(udp_tx_pkg::ADDR_SEND, 32'h1);
            foreach (model_words[k]) begin
                if (ext) begin
                    pay_words.push_back(model_words[k]);
                    pay_lasts.push_back(k == n - 1);
                end
            end
            push_frame_model(n);
        end
        while (frames_done < frames_sent) @(negedge clk);
        repeat (3) @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the frames did not finish within the expected time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst         = 1'b1;
        csr_wr_en   = 1'b0;
        csr_addr    = '0;
        csr_wr_data = '0;
        pay_tdata   = '0;
        pay_tvalid  = 1'b0;
        pay_tlast   = 1'b0;
        tx_tready   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        readback_test();
        for (int i = 0; i < 3; i++) send_frame(1'b0, i[0], 0);
        send_frame(1'b0, 1'b1, 1);
        send_frame(1'b0, 1'b0, 2);
        for (int i = 0; i < 5; i++) send_frame(1'b1, 1'b1, 0);
        repeat (5) @(posedge clk);
        assert (frames_done == NUM_FRAMES)
            else report_error($sformatf("%0d frames seen, expected %0d", frames_done, NUM_FRAMES));
        csr_read_check(udp_tx_pkg::ADDR_SEND, 32'h0);
        csr_read_check(udp_tx_pkg::ADDR_TX_BEATS, 32'(exp_beat_sum));
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/udp_tx_pkg.sv
source/udp_csr_regs.sv
source/udp_ramp_source.sv
source/ipv4_checksum.sv
source/udp_frame_tx.sv
source/udp10g_tx.sv
dv/udp10g_tx_asserts.sv
dv/udp10g_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module udp10g_tx_tb \
    -f filelist.f -o udp10g_tx_sim \
    && { ./obj_dir/udp10g_tx_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Checks failed" sim.log \
    && grep -q "All checks passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* source/ipv4_checksum.sv */
`timescale 1ns/1ps

module ipv4_checksum (
    input  logic        i_clk,
    input  logic [15:0] i_total_len,
    input  logic [7:0]  i_ttl,
    input  logic [31:0] i_src_ip,
    input  logic [31:0] i_dst_ip,
    output logic [15:0] o_checksum
);

    logic [19:0] sum;
    logic [16:0] fold1;
    logic [15:0] fold2;

    // Identification, flags and checksum words are zero and drop out
    assign sum = 20'({udp_tx_pkg::IP_VER_IHL, 8'h00})
               + 20'(i_total_len)
               + 20'({i_ttl, udp_tx_pkg::IP_PROTO_UDP})
               + 20'(i_src_ip[31:16])
               + 20'(i_src_ip[15:0])
               + 20'(i_dst_ip[31:16])
               + 20'(i_dst_ip[15:0]);

    // End-around carry, second fold catches the carry of the first
    assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    always_ff @(posedge i_clk) begin
        o_checksum <= ~fold2;
    end

endmodule

/* source/udp10g_tx.sv */
`timescale 1ns/1ps

module udp10g_tx (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_csr_wr_en,
    input  logic [udp_tx_pkg::CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [udp_tx_pkg::CSR_DATA_W-1:0] i_csr_wr_data,
    input  logic [udp_tx_pkg::DATA_W-1:0]     i_pay_tdata,
    input  logic                              i_pay_tvalid,
    input  logic                              i_pay_tlast,
    input  logic                              i_tx_tready,
    output logic [udp_tx_pkg::CSR_DATA_W-1:0] o_csr_rd_data,
    output logic                              o_pay_tready,
    output logic [udp_tx_pkg::DATA_W-1:0]     o_tx_tdata,
    output logic [udp_tx_pkg::KEEP_W-1:0]     o_tx_tkeep,
    output logic                              o_tx_tvalid,
    output logic                              o_tx_tlast
);

    logic                          ramp_en;
    logic                          hdr_valid;
    logic                          hdr_ready;
    logic [47:0]                   dst_mac;
    logic [47:0]                   src_mac;
    logic [31:0]                   src_ip;
    logic [31:0]                   dst_ip;
    logic [15:0]                   src_port;
    logic [15:0]                   dst_port;
    logic [7:0]                    ttl;
    logic [udp_tx_pkg::LEN_W-1:0]  payload_words;
    logic [udp_tx_pkg::DATA_W-1:0] pay_tdata;
    logic                          pay_tvalid;
    logic                          pay_tlast;
    logic                          pay_tready;
    logic                          tx_beat;

    assign tx_beat = o_tx_tvalid & i_tx_tready;

    udp_csr_regs u_csr (
        .i_clk           ( i_clk         ),
        .i_rst           ( i_rst         ),
        .i_csr_wr_en     ( i_csr_wr_en   ),
        .i_csr_addr      ( i_csr_addr    ),
        .i_csr_wr_data   ( i_csr_wr_data ),
        .i_hdr_ready     ( hdr_ready     ),
        .i_tx_beat       ( tx_beat       ),
        .o_csr_rd_data   ( o_csr_rd_data ),
        .o_ramp_en       ( ramp_en       ),
        .o_hdr_valid     ( hdr_valid     ),
        .o_dst_mac       ( dst_mac       ),
        .o_src_mac       ( src_mac       ),
        .o_src_ip        ( src_ip        ),
        .o_dst_ip        ( dst_ip        ),
        .o_src_port      ( src_port      ),
        .o_dst_port      ( dst_port      ),
        .o_ttl           ( ttl           ),
        .o_payload_words ( payload_words )
    );

    udp_ramp_source u_ramp (
        .i_clk           ( i_clk         ),
        .i_rst           ( i_rst         ),
        .i_ramp_en       ( ramp_en       ),
        .i_payload_words ( payload_words ),
        .i_pay_tdata     ( i_pay_tdata   ),
        .i_pay_tvalid    ( i_pay_tvalid  ),
        .i_pay_tlast     ( i_pay_tlast   ),
        .i_pay_tready    ( pay_tready    ),
        .o_pay_tready    ( o_pay_tready  ),
        .o_pay_tdata     ( pay_tdata     ),
        .o_pay_tvalid    ( pay_tvalid    ),
        .o_pay_tlast     ( pay_tlast     )
    );

    udp_frame_tx u_frame (
        .i_clk           ( i_clk         ),
        .i_rst           ( i_rst         ),
        .i_hdr_valid     ( hdr_valid     ),
        .i_dst_mac       ( dst_mac       ),
        .i_src_mac       ( src_mac       ),
        .i_src_ip        ( src_ip        ),
        .i_dst_ip        ( dst_ip        ),
        .i_src_port      ( src_port      ),
        .i_dst_port      ( dst_port      ),
        .i_ttl           ( ttl           ),
        .i_payload_words ( payload_words ),
        .i_pay_tdata     ( pay_tdata     ),
        .i_pay_tvalid    ( pay_tvalid    ),
        .i_pay_tlast     ( pay_tlast     ),
        .i_tx_tready     ( i_tx_tready   ),
        .o_hdr_ready     ( hdr_ready     ),
        .o_pay_tready    ( pay_tready    ),
        .o_tx_tdata      ( o_tx_tdata    ),
        .o_tx_tkeep      ( o_tx_tkeep    ),
        .o_tx_tvalid     ( o_tx_tvalid   ),
        .o_tx_tlast      ( o_tx_tlast    )
    );

endmodule

/* source/udp_csr_regs.sv */
`timescale 1ns/1ps

module udp_csr_regs (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_csr_wr_en,
    input  logic [udp_tx_pkg::CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [udp_tx_pkg::CSR_DATA_W-1:0] i_csr_wr_data,
    input  logic                              i_hdr_ready,
    input  logic                              i_tx_beat,
    output logic [udp_tx_pkg::CSR_DATA_W-1:0] o_csr_rd_data,
    output logic                              o_ramp_en,
    output logic                              o_hdr_valid,
    output logic [47:0]                       o_dst_mac,
    output logic [47:0]                       o_src_mac,
    output logic [31:0]                       o_src_ip,
    output logic [31:0]                       o_dst_ip,
    output logic [15:0]                       o_src_port,
    output logic [15:0]                       o_dst_port,
    output logic [7:0]                        o_ttl,
    output logic [udp_tx_pkg::LEN_W-1:0]      o_payload_words
);

    logic [31:0] tx_beats;
    logic        send_wr;

    assign send_wr = i_csr_wr_en && (i_csr_addr == udp_tx_pkg::ADDR_SEND) && i_csr_wr_data[0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ramp_en       <= 1'b0;
            o_dst_mac       <= '0;
            o_src_mac       <= '0;
            o_src_ip        <= '0;
            o_dst_ip        <= '0;
            o_src_port      <= '0;
            o_dst_port      <= '0;
            o_ttl           <= '0;
            o_payload_words <= '0;
        end else if (i_csr_wr_en) begin
            case (i_csr_addr)
                udp_tx_pkg::ADDR_CTRL:       o_ramp_en         <= i_csr_wr_data[0];
                udp_tx_pkg::ADDR_SRC_MAC_LO: o_src_mac[31:0]   <= i_csr_wr_data;
                udp_tx_pkg::ADDR_SRC_MAC_HI: o_src_mac[47:32]  <= i_csr_wr_data[15:0];
                udp_tx_pkg::ADDR_DST_MAC_LO: o_dst_mac[31:0]   <= i_csr_wr_data;
                udp_tx_pkg::ADDR_DST_MAC_HI: o_dst_mac[47:32]  <= i_csr_wr_data[15:0];
                udp_tx_pkg::ADDR_SRC_IP:     o_src_ip          <= i_csr_wr_data;
                udp_tx_pkg::ADDR_DST_IP:     o_dst_ip          <= i_csr_wr_data;
                udp_tx_pkg::ADDR_PORTS: begin
                    o_src_port <= i_csr_wr_data[31:16];
                    o_dst_port <= i_csr_wr_data[15:0];
                end
                udp_tx_pkg::ADDR_LEN_TTL: begin
                    o_payload_words <= i_csr_wr_data[15:0];
                    o_ttl           <= i_csr_wr_data[23:16];
                end
                default: ;
            endcase
        end
    end

    // New request wins over a handshake in the same cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_hdr_valid <= 1'b0;
        end else if (send_wr) begin
            o_hdr_valid <= 1'b1;
        end else if (o_hdr_valid && i_hdr_ready) begin
            o_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tx_beats <= '0;
        end else if (i_tx_beat) begin
            tx_beats <= tx_beats + 1'b1;
        end
    end

    always_comb begin
        o_csr_rd_data = '0;
        case (i_csr_addr)
            udp_tx_pkg::ADDR_CTRL:       o_csr_rd_data[0]     = o_ramp_en;
            udp_tx_pkg::ADDR_SEND:       o_csr_rd_data[0]     = o_hdr_valid;
            udp_tx_pkg::ADDR_SRC_MAC_LO: o_csr_rd_data        = o_src_mac[31:0];
            udp_tx_pkg::ADDR_SRC_MAC_HI: o_csr_rd_data[15:0]  = o_src_mac[47:32];
            udp_tx_pkg::ADDR_DST_MAC_LO: o_csr_rd_data        = o_dst_mac[31:0];
            udp_tx_pkg::ADDR_DST_MAC_HI: o_csr_rd_data[15:0]  = o_dst_mac[47:32];
            udp_tx_pkg::ADDR_SRC_IP:     o_csr_rd_data        = o_src_ip;
            udp_tx_pkg::ADDR_DST_IP:     o_csr_rd_data        = o_dst_ip;
            udp_tx_pkg::ADDR_PORTS:      o_csr_rd_data        = {o_src_port, o_dst_port};
            udp_tx_pkg::ADDR_LEN_TTL:    o_csr_rd_data[23:0]  = {o_ttl, o_payload_words};
            udp_tx_pkg::ADDR_TX_BEATS:   o_csr_rd_data        = tx_beats;
            default: ;
        endcase
    end

endmodule

/* source/udp_frame_tx.sv */
`timescale 1ns/1ps

module udp_frame_tx (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_hdr_valid,
    input  logic [47:0]                   i_dst_mac,
    input  logic [47:0]                   i_src_mac,
    input  logic [31:0]                   i_src_ip,
    input  logic [31:0]                   i_dst_ip,
    input  logic [15:0]                   i_src_port,
    input  logic [15:0]                   i_dst_port,
    input  logic [7:0]                    i_ttl,
    input  logic [udp_tx_pkg::LEN_W-1:0]  i_payload_words,
    input  logic [udp_tx_pkg::DATA_W-1:0] i_pay_tdata,
    input  logic                          i_pay_tvalid,
    input  logic                          i_pay_tlast,
    input  logic                          i_tx_tready,
    output logic                          o_hdr_ready,
    output logic                          o_pay_tready,
    output logic [udp_tx_pkg::DATA_W-1:0] o_tx_tdata,
    output logic [udp_tx_pkg::KEEP_W-1:0] o_tx_tkeep,
    output logic                          o_tx_tvalid,
    output logic                          o_tx_tlast
);

    // One-hot FSM, idle when no flag is set
    logic st_csum;
    logic st_hdr;
    logic st_pay;
    logic st_last;

    logic [2:0]                   hdr_beat;
    logic [udp_tx_pkg::LEN_W-1:0] word_cnt;
    logic [15:0]                  carry;

    // Fields captured at the header handshake
    logic [47:0]                  dst_mac;
    logic [47:0]                  src_mac;
    logic [31:0]                  src_ip;
    logic [31:0]                  dst_ip;
    logic [15:0]                  src_port;
    logic [15:0]                  dst_port;
    logic [7:0]                   ttl;
    logic [udp_tx_pkg::LEN_W-1:0] pl_words;

    logic [15:0]  total_len;
    logic [15:0]  udp_len;
    logic [15:0]  csum;
    logic [319:0] hdr_be;
    logic [63:0]  hdr_word;

    logic hs;
    logic beat_acc;
    logic pay_acc;
    logic hdr_done;
    logic pay_done;

    assign o_hdr_ready = !(st_csum || st_hdr || st_pay || st_last);
    assign hs          = i_hdr_valid && o_hdr_ready;
    assign beat_acc    = o_tx_tvalid && i_tx_tready;
    assign pay_acc     = st_pay && beat_acc;
    assign hdr_done    = (hdr_beat == 3'(udp_tx_pkg::HDR_BYTES / udp_tx_pkg::KEEP_W - 1));
    // Early tlast truncates the frame
    assign pay_done    = (word_cnt == pl_words - 1'b1) || i_pay_tlast;

    assign udp_len   = 16'(udp_tx_pkg::UDP_HDR_BYTES) + {pl_words[12:0], 3'b000};
    assign total_len = 16'(udp_tx_pkg::IP_HDR_BYTES) + udp_len;

    ipv4_checksum u_csum (
        .i_clk       ( i_clk     ),
        .i_total_len ( total_len ),
        .i_ttl       ( ttl       ),
        .i_src_ip    ( src_ip    ),
        .i_dst_ip    ( dst_ip    ),
        .o_checksum  ( csum      )
    );

    // First 40 header bytes, byte 0 in the top bits
    assign hdr_be = {dst_mac, src_mac, udp_tx_pkg::ETHERTYPE_IPV4,
                     udp_tx_pkg::IP_VER_IHL, 8'h00, total_len, 32'h0,
                     ttl, udp_tx_pkg::IP_PROTO_UDP, csum, src_ip, dst_ip,
                     src_port, dst_port, udp_len};

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            hdr_word[8*b +: 8] = hdr_be[319 - 64*hdr_beat - 8*b -: 8];
        end
    end

    always_comb begin
        o_tx_tdata   = hdr_word;
        o_tx_tkeep   = '1;
        o_tx_tlast   = 1'b0;
        o_tx_tvalid  = st_hdr;
        o_pay_tready = 1'b0;
        if (st_pay) begin
            // Two bytes held back from the previous word, six from this one
            o_tx_tdata   = {i_pay_tdata[udp_tx_pkg::DATA_W-17:0], carry};
            o_tx_tvalid  = i_pay_tvalid;
            o_pay_tready = i_tx_tready;
        end
        if (st_last) begin
            o_tx_tdata  = {{(udp_tx_pkg::DATA_W - 16){1'b0}}, carry};
            o_tx_tkeep  = {{(udp_tx_pkg::KEEP_W - 2){1'b0}}, 2'b11};
            o_tx_tlast  = 1'b1;
            o_tx_tvalid = 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            st_csum  <= 1'b0;
            st_hdr   <= 1'b0;
            st_pay   <= 1'b0;
            st_last  <= 1'b0;
            hdr_beat <= '0;
            word_cnt <= '0;
        end else begin
            st_csum <= hs;
            if (hs) begin
                hdr_beat <= '0;
                word_cnt <= '0;
            end
            if (st_csum) begin
                st_hdr <= 1'b1;
            end
            if (st_hdr && beat_acc) begin
                hdr_beat <= hdr_beat + 1'b1;
                if (hdr_done) begin
                    st_hdr <= 1'b0;
                    st_pay <= 1'b1;
                end
            end
            if (pay_acc) begin
                word_cnt <= word_cnt + 1'b1;
                if (pay_done) begin
                    st_pay  <= 1'b0;
                    st_last <= 1'b1;
                end
            end
            if (st_last && beat_acc) begin
                st_last <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (hs) begin
            dst_mac  <= i_dst_mac;
            src_mac  <= i_src_mac;
            src_ip   <= i_src_ip;
            dst_ip   <= i_dst_ip;
            src_port <= i_src_port;
            dst_port <= i_dst_port;
            ttl      <= i_ttl;
            pl_words <= i_payload_words;
            // UDP checksum field rides in the carry
            carry    <= 16'h0000;
        end else if (pay_acc) begin
            carry <= i_pay_tdata[udp_tx_pkg::DATA_W-1 -: 16];
        end
    end

endmodule

/* source/udp_ramp_source.sv */
`timescale 1ns/1ps

module udp_ramp_source (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_ramp_en,
    input  logic [udp_tx_pkg::LEN_W-1:0]  i_payload_words,
    input  logic [udp_tx_pkg::DATA_W-1:0] i_pay_tdata,
    input  logic                          i_pay_tvalid,
    input  logic                          i_pay_tlast,
    input  logic                          i_pay_tready,
    output logic                          o_pay_tready,
    output logic [udp_tx_pkg::DATA_W-1:0] o_pay_tdata,
    output logic                          o_pay_tvalid,
    output logic                          o_pay_tlast
);

    logic [udp_tx_pkg::LEN_W-1:0] count;
    logic [udp_tx_pkg::LEN_W-1:0] last_idx;
    logic                         count_done;

    assign last_idx   = i_payload_words - 1'b1;
    assign count_done = (count == last_idx);

    always_comb begin
        if (i_ramp_en) begin
            o_pay_tdata  = {{(udp_tx_pkg::DATA_W - udp_tx_pkg::LEN_W){1'b0}}, count};
            o_pay_tvalid = 1'b1;
            o_pay_tlast  = count_done;
            o_pay_tready = 1'b0;
        end else begin
            o_pay_tdata  = i_pay_tdata;
            o_pay_tvalid = i_pay_tvalid;
            o_pay_tlast  = i_pay_tlast;
            o_pay_tready = i_pay_tready;
        end
    end

    // Ramp always offers a beat, so ready alone advances it
    always_ff @(posedge i_clk) begin
        if (i_rst || !i_ramp_en) begin
            count <= '0;
        end else if (i_pay_tready) begin
            count <= count_done ? '0 : count + 1'b1;
        end
    end

endmodule

/* source/udp_tx_pkg.sv */
package udp_tx_pkg;

    // Stream geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // Register port
    localparam int CSR_ADDR_W = 4;
    localparam int CSR_DATA_W = 32;
    localparam int LEN_W      = 16;

    // Ethernet + IPv4 + UDP, no options
    localparam int HDR_BYTES     = 42;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // Register map
    localparam logic [CSR_ADDR_W-1:0] ADDR_CTRL       = 4'd0;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SEND       = 4'd1;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SRC_MAC_LO = 4'd2;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SRC_MAC_HI = 4'd3;
    localparam logic [CSR_ADDR_W-1:0] ADDR_DST_MAC_LO = 4'd4;
    localparam logic [CSR_ADDR_W-1:0] ADDR_DST_MAC_HI = 4'd5;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SRC_IP     = 4'd6;
    localparam logic [CSR_ADDR_W-1:0] ADDR_DST_IP     = 4'd7;
    localparam logic [CSR_ADDR_W-1:0] ADDR_PORTS      = 4'd8;
    localparam logic [CSR_ADDR_W-1:0] ADDR_LEN_TTL    = 4'd9;
    localparam logic [CSR_ADDR_W-1:0] ADDR_TX_BEATS   = 4'd10;

endpackage
